// ==== Makefile ====
LOG = sim.log

all: run

compile:
	verilator --binary --timing -Wno-fatal --top-module tb_core -f flist.f

run: compile
	./obj_dir/Vtb_core | tee $(LOG)
	grep -qx '\*\* PASS \*\*' $(LOG)

clean:
	rm -rf obj_dir $(LOG)

.PHONY: all compile run clean

// ==== alu.sv ====
`default_nettype none

module alu (
  input  wire rv_pkg::word_t   a,
  input  wire rv_pkg::word_t   b,
  input  wire rv_pkg::alu_op_t op,
  output rv_pkg::word_t        y,
  output logic                 zero
);

  always_comb begin
    case (op)
      rv_pkg::alu_add: y = a + b;
      rv_pkg::alu_sub: y = a - b;
      rv_pkg::alu_and: y = a & b;
      rv_pkg::alu_or:  y = a | b;
      rv_pkg::alu_xor: y = a ^ b;
      rv_pkg::alu_slt: y = {31'b0, $signed(a) < $signed(b)};
      default:         y = '0;
    endcase
  end

  assign zero = (y == '0);                      // Equal operands under sub.

endmodule

`default_nettype wire

// ==== control_fsm.sv ====
`default_nettype none

module control_fsm (
  input  wire logic            clk,
  input  wire logic            arst_n,
  input  wire rv_pkg::opcode_t opcode,
  input  wire logic [2:0]      funct3,
  input  wire logic            zero,
  output rv_pkg::ctrl_t        ctrl,
  output logic                 halt
);

  rv_pkg::fsm_state_t state;
  rv_pkg::fsm_state_t state_nxt;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state <= rv_pkg::s_fetch;
    end else begin
      state <= state_nxt;
    end
  end

  // ------------------------------
  // Next state
  // ------------------------------
  always_comb begin
    state_nxt = rv_pkg::s_halt;
    case (state)
      rv_pkg::s_fetch:  state_nxt = rv_pkg::s_decode;
      rv_pkg::s_decode: begin
        case (opcode)
          rv_pkg::op_r:      state_nxt = rv_pkg::s_exec_r;
          rv_pkg::op_imm:    state_nxt = rv_pkg::s_exec_i;
          rv_pkg::op_load:   state_nxt = rv_pkg::s_mem_adr;
          rv_pkg::op_store:  state_nxt = rv_pkg::s_mem_adr;
          rv_pkg::op_jal:    state_nxt = rv_pkg::s_jal;
          rv_pkg::op_branch: begin
            // Only beq and bne exist here.
            state_nxt = (funct3[2:1] == 2'b00) ? rv_pkg::s_branch : rv_pkg::s_halt;
          end
          default:           state_nxt = rv_pkg::s_halt;   // ecall and illegal opcodes.
        endcase
      end
      rv_pkg::s_mem_adr: begin
        state_nxt = (opcode == rv_pkg::op_store) ? rv_pkg::s_mem_write : rv_pkg::s_mem_read;
      end
      rv_pkg::s_mem_read:  state_nxt = rv_pkg::s_mem_wb;
      rv_pkg::s_exec_r,
      rv_pkg::s_exec_i,
      rv_pkg::s_jal:       state_nxt = rv_pkg::s_alu_wb;
      rv_pkg::s_mem_wb,
      rv_pkg::s_mem_write,
      rv_pkg::s_alu_wb,
      rv_pkg::s_branch:    state_nxt = rv_pkg::s_fetch;
      default:             state_nxt = rv_pkg::s_halt;
    endcase
  end

  // ------------------------------
  // Control word
  // ------------------------------
  always_comb begin
    ctrl = '0;
    ctrl.alu_force_add = 1'b1;
    case (state)
      rv_pkg::s_fetch: begin
        ctrl.ir_write   = 1'b1;
        ctrl.pc_update  = 1'b1;
        ctrl.alu_src_b  = rv_pkg::src_b_four;     // PC + 4.
        ctrl.result_src = rv_pkg::res_alu_result;
      end
      rv_pkg::s_decode: begin
        ctrl.alu_src_a = rv_pkg::src_a_old_pc;    // Branch or jump target.
        ctrl.alu_src_b = rv_pkg::src_b_imm;
      end
      rv_pkg::s_mem_adr: begin
        ctrl.alu_src_a = rv_pkg::src_a_rs1;
        ctrl.alu_src_b = rv_pkg::src_b_imm;
      end
      rv_pkg::s_mem_read: ctrl.adr_src = rv_pkg::adr_result;
      rv_pkg::s_mem_write: begin
        ctrl.adr_src   = rv_pkg::adr_result;
        ctrl.mem_write = 1'b1;
      end
      rv_pkg::s_mem_wb: begin
        ctrl.result_src = rv_pkg::res_mem_data;
        ctrl.reg_write  = 1'b1;
      end
      rv_pkg::s_exec_r: begin
        ctrl.alu_src_a     = rv_pkg::src_a_rs1;
        ctrl.alu_force_add = 1'b0;
      end
      rv_pkg::s_exec_i: begin
        ctrl.alu_src_a     = rv_pkg::src_a_rs1;
        ctrl.alu_src_b     = rv_pkg::src_b_imm;
        ctrl.alu_force_add = 1'b0;
      end
      rv_pkg::s_alu_wb: ctrl.reg_write = 1'b1;
      rv_pkg::s_branch: begin
        ctrl.alu_src_a     = rv_pkg::src_a_rs1;
        ctrl.alu_force_add = 1'b0;                // Decode picks sub.
        ctrl.branch_ne     = funct3[0];
        ctrl.branch        = 1'b1;
      end
      rv_pkg::s_jal: begin
        ctrl.pc_update = 1'b1;
        ctrl.alu_src_a = rv_pkg::src_a_old_pc;
        ctrl.alu_src_b = rv_pkg::src_b_four;      // Link address.
      end
      default: ctrl.alu_force_add = 1'b1;
    endcase
  end

  assign halt = (state == rv_pkg::s_halt);

endmodule

`default_nettype wire

// ==== decode.sv ====
`default_nettype none

module decode (
  input  wire logic           clk,
  input  wire logic           arst_n,
  input  wire rv_pkg::instr_t instr,
  input  wire logic           reg_write,
  input  wire rv_pkg::word_t  wb_data,
  input  wire logic           alu_force_add,
  output rv_pkg::opcode_t     opcode,
  output logic [2:0]          funct3,
  output rv_pkg::word_t       rd1,
  output rv_pkg::word_t       rd2,
  output rv_pkg::word_t       imm,
  output rv_pkg::alu_op_t     alu_op
);

  rv_pkg::reg_idx_t rs1;
  rv_pkg::reg_idx_t rs2;
  rv_pkg::reg_idx_t rd;
  rv_pkg::word_t    regs [1:31];
  rv_pkg::alu_op_t  f3_op;

  assign opcode = rv_pkg::opcode_t'(instr[6:0]);
  assign funct3 = instr[14:12];
  assign rs1    = instr[19:15];
  assign rs2    = instr[24:20];
  assign rd     = instr[11:7];

  // ------------------------------
  // Immediates
  // ------------------------------
  always_comb begin
    case (opcode)
      rv_pkg::op_store:  imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
      rv_pkg::op_branch: imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                                instr[11:8], 1'b0};
      rv_pkg::op_jal:    imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                                instr[30:21], 1'b0};
      default:           imm = {{20{instr[31]}}, instr[31:20]};
    endcase
  end

  // ------------------------------
  // ALU control
  // ------------------------------
  always_comb begin
    case (funct3)
      3'b010:  f3_op = rv_pkg::alu_slt;
      3'b100:  f3_op = rv_pkg::alu_xor;
      3'b110:  f3_op = rv_pkg::alu_or;
      3'b111:  f3_op = rv_pkg::alu_and;
      default: f3_op = rv_pkg::alu_add;
    endcase
  end

  always_comb begin
    if (alu_force_add) begin
      alu_op = rv_pkg::alu_add;
    end else if (opcode == rv_pkg::op_branch) begin
      alu_op = rv_pkg::alu_sub;                  // Compare for beq and bne.
    end else if (opcode == rv_pkg::op_r && funct3 == 3'b000 && instr[30]) begin
      alu_op = rv_pkg::alu_sub;
    end else begin
      alu_op = f3_op;
    end
  end

  // ------------------------------
  // Register file
  // ------------------------------
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (reg_write && rd != '0) begin
      regs[rd] <= wb_data;
    end
  end

  assign rd1 = (rs1 == '0) ? '0 : regs[rs1];   // x0 reads as zero.
  assign rd2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

// ==== fetch.sv ====
`default_nettype none

module fetch (
  input  wire logic          clk,
  input  wire logic          arst_n,
  input  wire rv_pkg::ctrl_t ctrl,
  input  wire logic          zero,
  input  wire rv_pkg::word_t result,
  output rv_pkg::addr_t      pc,
  output rv_pkg::addr_t      old_pc
);

  logic taken;
  logic pc_en;

  assign taken = ctrl.branch && (ctrl.branch_ne ? !zero : zero);
  assign pc_en = ctrl.pc_update || taken;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pc     <= '0;
      old_pc <= '0;
    end else begin
      if (pc_en) pc <= result;
      if (ctrl.ir_write) old_pc <= pc;          // Address of the fetched instruction.
    end
  end

endmodule

`default_nettype wire

// ==== flist.f ====
rv_pkg.sv
control_fsm.sv
fetch.sv
decode.sv
alu.sv
unified_mem.sv
mem_align.sv
rv_core.sv
tb_clock_gen.sv
tb_core.sv

// ==== mem_align.sv ====
`default_nettype none

module mem_align (
  input  wire rv_pkg::word_t rdata,
  input  wire rv_pkg::addr_t addr,
  input  wire logic [2:0]    funct3,
  input  wire rv_pkg::word_t store_src,
  input  wire logic          write,
  output rv_pkg::word_t      load_val,
  output rv_pkg::word_t      wdata,
  output rv_pkg::byte_en_t   byte_en
);

  logic [7:0]       lane;
  rv_pkg::byte_en_t mask;

  // ------------------------------
  // Load side
  // ------------------------------
  assign lane = rdata[8*addr[1:0] +: 8];

  always_comb begin
    if (funct3[1]) begin
      load_val = rdata;                          // lw.
    end else if (funct3[2]) begin
      load_val = {24'b0, lane};                  // lbu.
    end else begin
      load_val = {{24{lane[7]}}, lane};          // lb.
    end
  end

  // ------------------------------
  // Store side
  // ------------------------------
  assign wdata   = funct3[1] ? store_src : {4{store_src[7:0]}};
  assign mask    = funct3[1] ? 4'b1111 : (4'b0001 << addr[1:0]);
  assign byte_en = write ? mask : '0;

endmodule

`default_nettype wire

// ==== rv_core.sv ====
`default_nettype none

module rv_core (
  input  wire logic               clk,
  input  wire logic               arst_n,
  input  wire rv_pkg::load_port_t load,
  output rv_pkg::store_obs_t      store_obs,
  output logic                    halt
);

  rv_pkg::ctrl_t    ctrl;
  rv_pkg::opcode_t  opcode;
  logic [2:0]       funct3;
  logic             zero;
  rv_pkg::addr_t    pc;
  rv_pkg::addr_t    old_pc;
  rv_pkg::addr_t    mem_addr;
  rv_pkg::instr_t   ir;
  rv_pkg::word_t    rdata, load_val, wdata;
  rv_pkg::byte_en_t byte_en;
  rv_pkg::word_t    data_q, a_q, b_q, alu_out;
  rv_pkg::word_t    rd1, rd2, imm;
  rv_pkg::alu_op_t  alu_op;
  rv_pkg::word_t    src_a, src_b, alu_result, result;

  control_fsm control_fsm_i (
    .clk, .arst_n, .opcode, .funct3, .zero, .ctrl, .halt
  );

  fetch fetch_i (
    .clk, .arst_n, .ctrl, .zero, .result, .pc, .old_pc
  );

  decode decode_i (
    .clk, .arst_n, .instr(ir), .reg_write(ctrl.reg_write), .wb_data(result),
    .alu_force_add(ctrl.alu_force_add), .opcode, .funct3, .rd1, .rd2, .imm, .alu_op
  );

  alu alu_i (.a(src_a), .b(src_b), .op(alu_op), .y(alu_result), .zero);

  unified_mem unified_mem_i (.clk, .addr(mem_addr), .wdata, .byte_en, .load, .rdata);

  mem_align mem_align_i (
    .rdata, .addr(mem_addr), .funct3, .store_src(b_q), .write(ctrl.mem_write),
    .load_val, .wdata, .byte_en
  );

  // ------------------------------
  // Datapath registers
  // ------------------------------
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ir <= '0;
    end else if (ctrl.ir_write) begin
      ir <= rdata;
    end
  end

  always_ff @(posedge clk) begin
    data_q  <= load_val;
    a_q     <= rd1;
    b_q     <= rd2;
    alu_out <= alu_result;
  end

  // ------------------------------
  // Multiplexers
  // ------------------------------
  assign mem_addr = (ctrl.adr_src == rv_pkg::adr_pc) ? pc : result;

  always_comb begin
    case (ctrl.alu_src_a)
      rv_pkg::src_a_pc:     src_a = pc;
      rv_pkg::src_a_old_pc: src_a = old_pc;
      rv_pkg::src_a_rs1:    src_a = a_q;
      default:              src_a = '0;
    endcase
    case (ctrl.alu_src_b)
      rv_pkg::src_b_rs2:    src_b = b_q;
      rv_pkg::src_b_imm:    src_b = imm;
      default:              src_b = 32'd4;
    endcase
    case (ctrl.result_src)
      rv_pkg::res_mem_data:   result = data_q;
      rv_pkg::res_alu_result: result = alu_result;
      default:                result = alu_out;
    endcase
  end

  // Mirrors the memory write port.
  assign store_obs.valid   = ctrl.mem_write;
  assign store_obs.addr    = mem_addr;
  assign store_obs.data    = wdata;
  assign store_obs.byte_en = byte_en;

endmodule

`default_nettype wire

// ==== rv_pkg.sv ====
`default_nettype none

package rv_pkg;

  // ------------------------------
  // Widths and sizes
  // ------------------------------
  typedef logic [31:0] word_t;
  typedef logic [31:0] addr_t;
  typedef logic [31:0] instr_t;
  typedef logic [4:0]  reg_idx_t;
  typedef logic [3:0]  byte_en_t;

  localparam int mem_words = 1024;               // Memory depth in words.
  localparam int mem_idx_w = $clog2(mem_words);

  // ------------------------------
  // Encodings
  // ------------------------------
  typedef enum logic [6:0] {
    op_r      = 7'b0110011,
    op_imm    = 7'b0010011,
    op_load   = 7'b0000011,
    op_store  = 7'b0100011,
    op_branch = 7'b1100011,
    op_jal    = 7'b1101111,
    op_system = 7'b1110011
  } opcode_t;

  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_slt
  } alu_op_t;

  typedef enum logic {adr_pc, adr_result} adr_src_t;
  typedef enum logic [1:0] {src_a_pc, src_a_old_pc, src_a_rs1, src_a_zero} alu_src_a_t;
  typedef enum logic [1:0] {src_b_rs2, src_b_imm, src_b_four} alu_src_b_t;
  typedef enum logic [1:0] {res_alu_out, res_mem_data, res_alu_result} result_src_t;

  typedef enum logic [3:0] {
    s_fetch, s_decode, s_mem_adr, s_mem_read, s_mem_wb, s_mem_write,
    s_exec_r, s_exec_i, s_alu_wb, s_branch, s_jal, s_halt
  } fsm_state_t;

  // ------------------------------
  // Bundles
  // ------------------------------
  typedef struct packed {
    logic        pc_update;
    logic        ir_write;
    logic        reg_write;
    logic        mem_write;
    logic        branch;
    logic        branch_ne;
    adr_src_t    adr_src;
    alu_src_a_t  alu_src_a;
    alu_src_b_t  alu_src_b;
    result_src_t result_src;
    logic        alu_force_add;
  } ctrl_t;

  typedef struct packed {
    logic                 en;
    logic [mem_idx_w-1:0] addr;                  // Word index.
    word_t                data;
  } load_port_t;

  typedef struct packed {
    logic     valid;
    addr_t    addr;
    word_t    data;
    byte_en_t byte_en;
  } store_obs_t;

endpackage

`default_nettype wire

// ==== tb_clock_gen.sv ====
`default_nettype none

module tb_clock_gen (
  input  wire logic hold,
  output logic      clk,
  output logic      arst_n
);

  timeunit 1ns;
  timeprecision 100ps;

  localparam int rst_cycles = 4;

  int cnt = 0;

  initial begin
    clk    = 1'b0;
    arst_n = 1'b0;
    forever #20 clk = ~clk;                     // 40 ns period.
  end

  // Reset stays low while hold is high, then for four more cycles.
  always @(negedge clk or posedge hold) begin
    if (hold) begin
      cnt    <= 0;
      arst_n <= 1'b0;
    end else if (cnt < rst_cycles) begin
      cnt    <= cnt + 1;
      arst_n <= (cnt == rst_cycles - 1);
    end
  end

endmodule

`default_nettype wire

// ==== tb_core.sv ====
`default_nettype none

module tb_core;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int          halt_timeout = 2000;
  localparam int          quiet_cycles = 20;
  localparam int          model_steps  = 4000;
  localparam logic [6:0]  opc_r        = 7'b0110011;
  localparam logic [6:0]  opc_imm      = 7'b0010011;
  localparam logic [6:0]  opc_load     = 7'b0000011;
  localparam logic [6:0]  opc_store    = 7'b0100011;
  localparam logic [6:0]  opc_branch   = 7'b1100011;
  localparam logic [6:0]  opc_jal      = 7'b1101111;
  localparam logic [31:0] ecall_word   = 32'h00000073;

  logic               clk;
  logic               arst_n;
  logic               hold;
  rv_pkg::load_port_t load;
  rv_pkg::store_obs_t store_obs;
  logic               halt;

  int          seed = 70087;
  int          value_errors;
  int          other_errors;
  int          obs_cnt;
  int          total_stores;
  string       test_name;
  logic [31:0] prog[$];
  logic [31:0] exp_addr[$];
  logic [31:0] exp_data[$];
  logic [3:0]  exp_mask[$];

  tb_clock_gen clock_gen_i (.hold, .clk, .arst_n);

  rv_core dut_i (.clk, .arst_n, .load, .store_obs, .halt);

  // ------------------------------
  // Instruction encoding
  // ------------------------------
  function automatic logic [31:0] encode_r(int f7, int rs2, int rs1, int f3, int rd);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], opc_r};
  endfunction

  function automatic logic [31:0] encode_i(int imm, int rs1, int f3, int rd, logic [6:0] op);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op};
  endfunction

  function automatic logic [31:0] encode_s(int imm, int rs2, int rs1, int f3);
    return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], opc_store};
  endfunction

  function automatic logic [31:0] encode_b(int imm, int rs2, int rs1, int f3);
    return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], opc_branch};
  endfunction

  function automatic logic [31:0] encode_j(int imm, int rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], opc_jal};
  endfunction

  function automatic int pc_now();
    return prog.size() * 4;
  endfunction

  function automatic int rand_imm();
    return $random(seed) % 2048;                // Fits a signed 12-bit field.
  endfunction

  task automatic add_imm(int rd, int rs1, int imm);
    prog.push_back(encode_i(imm, rs1, 0, rd, opc_imm));
  endtask

  task automatic store_word(int rs2, int off);
    prog.push_back(encode_s(off, rs2, 31, 3'b010));   // Relative to x31.
  endtask

  function automatic logic [31:0] lane_bits(logic [3:0] be);
    return {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
  endfunction

  // ------------------------------
  // Reference ISA model
  // ------------------------------
  function automatic bit model_run();
    logic [31:0] mem [1024];
    logic [31:0] x [32];
    logic [31:0] pc, next, ins, a, b, imm, ea, word, res;
    logic [7:0]  bt;
    logic [2:0]  f3;
    bit          wr;
    bit          done;
    int          steps;
    int          i;

    for (i = 0; i < 1024; i++) begin
      mem[i] = (i < prog.size()) ? prog[i] : '0;
    end
    x = '{default: '0};
    exp_addr.delete();
    exp_data.delete();
    exp_mask.delete();
    pc    = '0;
    done  = 1'b0;
    steps = 0;
    while (!done && steps < model_steps) begin
      ins  = mem[pc[11:2]];
      a    = x[ins[19:15]];
      b    = x[ins[24:20]];
      f3   = ins[14:12];
      imm  = {{20{ins[31]}}, ins[31:20]};
      next = pc + 4;
      wr   = 1'b1;
      res  = '0;
      case (ins[6:0])
        opc_r: begin
          case (f3)
            3'b000:  res = ins[30] ? a - b : a + b;
            3'b010:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b100:  res = a ^ b;
            3'b110:  res = a | b;
            3'b111:  res = a & b;
            default: done = 1'b1;
          endcase
        end
        opc_imm: begin
          case (f3)
            3'b000:  res = a + imm;
            3'b110:  res = a | imm;
            3'b111:  res = a & imm;
            default: done = 1'b1;
          endcase
        end
        opc_load: begin
          ea   = a + imm;
          word = mem[ea[11:2]];
          bt   = word[{ea[1:0], 3'b000} +: 8];
          case (f3)
            3'b010:  res = word;
            3'b000:  res = {{24{bt[7]}}, bt};
            3'b100:  res = {24'b0, bt};
            default: done = 1'b1;
          endcase
        end
        opc_store: begin
          wr = 1'b0;
          ea = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
          if (f3 == 3'b010) begin
            mem[ea[11:2]] = b;
            exp_data.push_back(b);
            exp_mask.push_back(4'hF);
          end else begin
            mem[ea[11:2]][{ea[1:0], 3'b000} +: 8] = b[7:0];
            exp_data.push_back({24'b0, b[7:0]} << {ea[1:0], 3'b000});
            exp_mask.push_back(4'b0001 << ea[1:0]);
          end
          exp_addr.push_back(ea);
        end
        opc_branch: begin
          wr  = 1'b0;
          imm = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
          if ((f3 == 3'b000 && a == b) || (f3 == 3'b001 && a != b)) next = pc + imm;
        end
        opc_jal: begin
          res  = pc + 4;
          next = pc + {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
        end
        default: done = 1'b1;                   // ecall or an unsupported opcode.
      endcase
      if (wr && !done && ins[11:7] != 5'd0) x[ins[11:7]] = res;
      pc = next;
      steps++;
    end
    return done;
  endfunction

  // ------------------------------
  // Store comparison
  // ------------------------------
  task automatic report_value(string what, logic [31:0] expected, logic [31:0] actual);
    $display("** Error %s: %s expected 0x%08h, actual 0x%08h",
             test_name, what, expected, actual);
    value_errors++;
  endtask

  always @(negedge clk) begin
    if (store_obs.valid) begin
      if (obs_cnt >= exp_addr.size()) begin
        $display("Test %s: extra store to 0x%08h that the model does not make",
                 test_name, store_obs.addr);
        other_errors++;
      end else begin
        if (store_obs.addr != exp_addr[obs_cnt])
          report_value($sformatf("store %0d address", obs_cnt), exp_addr[obs_cnt],
                       store_obs.addr);
        if (store_obs.byte_en != exp_mask[obs_cnt])
          report_value($sformatf("store %0d mask", obs_cnt), {28'b0, exp_mask[obs_cnt]},
                       {28'b0, store_obs.byte_en});
        if ((store_obs.data & lane_bits(exp_mask[obs_cnt])) !=
            (exp_data[obs_cnt] & lane_bits(exp_mask[obs_cnt])))
          report_value($sformatf("store %0d data", obs_cnt), exp_data[obs_cnt],
                       store_obs.data);
      end
      obs_cnt++;
      total_stores++;
    end
  end

  // ------------------------------
  // Programs
  // ------------------------------
  task automatic build_alu();
    int r_f3 [6] = '{0, 0, 7, 6, 4, 2};
    int r_f7 [6] = '{0, 32, 0, 0, 0, 0};
    int off;
    int i;

    off = 0;
    prog.delete();
    add_imm(31, 0, 1024);
    repeat (3) begin
      add_imm(1, 0, rand_imm());
      add_imm(2, 0, rand_imm());
      for (i = 0; i < 6; i++) begin
        prog.push_back(encode_r(r_f7[i], 2, 1, r_f3[i], 3));
        store_word(3, off);
        off += 4;
      end
      prog.push_back(encode_r(0, 1, 2, 2, 3));          // slt, operands swapped.
      store_word(3, off);
      prog.push_back(encode_i(rand_imm(), 1, 7, 4, opc_imm));
      store_word(4, off + 4);
      prog.push_back(encode_i(rand_imm(), 1, 6, 5, opc_imm));
      store_word(5, off + 8);
      off += 12;
    end
    prog.push_back(ecall_word);
  endtask

  task automatic build_mem();
    int k;
    int v;

    prog.delete();
    add_imm(31, 0, 1024);
    add_imm(1, 0, rand_imm());
    store_word(1, 0);
    prog.push_back(encode_i(0, 31, 2, 2, opc_load));    // lw x2.
    store_word(2, 4);
    for (k = 0; k < 4; k++) begin
      v = (rand_imm() & 'h77F) | ((k % 2 == 0) ? 'h80 : 0);   // Sign bit on even lanes.
      add_imm(3, 0, v);
      prog.push_back(encode_s(8 + k, 3, 31, 0));         // sb.
      prog.push_back(encode_i(8 + k, 31, 0, 4, opc_load));
      store_word(4, 16 + 8 * k);
      prog.push_back(encode_i(8 + k, 31, 4, 5, opc_load));
      store_word(5, 20 + 8 * k);
    end
    prog.push_back(encode_i(8, 31, 2, 6, opc_load));
    store_word(6, 48);
    prog.push_back(ecall_word);
  endtask

  task automatic build_branch();
    int cnt;
    int loop;

    cnt = 1 + $unsigned($random(seed)) % 15;
    prog.delete();
    add_imm(31, 0, 1024);
    add_imm(1, 0, cnt);
    add_imm(2, 0, 0);
    loop = pc_now();
    add_imm(1, 1, -1);
    prog.push_back(encode_r(0, 2, 31, 0, 3));            // x3 = x31 + x2.
    prog.push_back(encode_s(0, 1, 3, 3'b010));
    add_imm(2, 2, 4);
    prog.push_back(encode_b(loop - pc_now(), 0, 1, 1));  // bne back to the loop.
    prog.push_back(encode_b(8, 0, 1, 0));                // beq taken.
    store_word(31, 508);
    prog.push_back(encode_b(8, 0, 2, 0));                // beq not taken.
    store_word(2, 512);
    prog.push_back(encode_b(8, 2, 2, 1));                // bne not taken.
    store_word(1, 516);
    prog.push_back(ecall_word);
  endtask

  task automatic build_jal();
    prog.delete();
    add_imm(31, 0, 1024);
    prog.push_back(encode_j(8, 1));
    store_word(31, 0);                                  // Skipped.
    store_word(1, 0);
    add_imm(0, 0, rand_imm());
    store_word(0, 4);
    prog.push_back(encode_j(8, 0));
    store_word(31, 4);
    prog.push_back(encode_r(0, 31, 31, 0, 0));
    store_word(0, 8);
    prog.push_back(encode_j(12, 2));
    store_word(31, 12);
    store_word(31, 16);
    store_word(2, 12);
    prog.push_back(ecall_word);
  endtask

  task automatic build_halt();
    prog.delete();
    add_imm(1, 0, rand_imm());
    prog.push_back(encode_s(1536, 1, 0, 3'b010));
    prog.push_back(ecall_word);
    prog.push_back(encode_s(1540, 1, 0, 3'b010));       // Past the ecall.
    add_imm(1, 1, 1);
    prog.push_back(encode_s(1544, 1, 0, 3'b010));
  endtask

  // ------------------------------
  // Test sequence
  // ------------------------------
  task automatic run_test(string name);
    int i;
    int cycles;
    int seen;

    test_name = name;
    if (!model_run()) begin
      $display("Test %s: the reference model did not reach an ecall", name);
      other_errors++;
    end
    obs_cnt = 0;
    hold    = 1'b1;
    for (i = 0; i < prog.size(); i++) begin
      @(negedge clk);
      load.en   = 1'b1;
      load.addr = i[rv_pkg::mem_idx_w-1:0];
      load.data = prog[i];
    end
    @(negedge clk);
    load = '0;
    hold = 1'b0;
    cycles = 0;
    while (!arst_n && cycles < 10) begin
      @(negedge clk);
      cycles++;
    end
    if (!arst_n) begin
      $display("Test %s: reset was not released", name);
      other_errors++;
    end
    cycles = 0;
    while (!halt && cycles < halt_timeout) begin
      @(negedge clk);
      cycles++;
    end
    if (!halt) begin
      $display("Test %s: timeout, halt did not rise within %0d cycles", name, halt_timeout);
      other_errors++;
    end
    seen = obs_cnt;
    repeat (quiet_cycles) @(negedge clk);
    if (obs_cnt != seen) begin
      $display("Test %s: %0d stores appeared after halt", name, obs_cnt - seen);
      other_errors++;
    end
    if (obs_cnt < exp_addr.size()) begin
      $display("Test %s: only %0d of %0d stores were seen", name, obs_cnt, exp_addr.size());
      other_errors++;
    end
  endtask

  initial begin
    hold         = 1'b1;
    load         = '0;
    value_errors = 0;
    other_errors = 0;
    obs_cnt      = 0;
    total_stores = 0;
    test_name    = "none";

    build_alu();
    run_test("alu");
    build_mem();
    run_test("memory");
    build_branch();
    run_test("branch");
    build_jal();
    run_test("jal");
    build_halt();
    run_test("halt");

    $display("Summary: %0d value errors, %0d other errors, %0d stores checked",
             value_errors, other_errors, total_stores);
    if (value_errors == 0 && other_errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== unified_mem.sv ====
`default_nettype none

module unified_mem (
  input  wire logic               clk,
  input  wire rv_pkg::addr_t      addr,
  input  wire rv_pkg::word_t      wdata,
  input  wire rv_pkg::byte_en_t   byte_en,
  input  wire rv_pkg::load_port_t load,
  output rv_pkg::word_t           rdata
);

  rv_pkg::word_t               mem [rv_pkg::mem_words];
  logic [rv_pkg::mem_idx_w-1:0] idx;

  assign idx   = addr[rv_pkg::mem_idx_w+1:2];   // Wraps at the memory size.
  assign rdata = mem[idx];

  always_ff @(posedge clk) begin
    if (load.en) begin
      mem[load.addr] <= load.data;
    end else begin
      for (int b = 0; b < 4; b++) begin
        if (byte_en[b]) mem[idx][8*b +: 8] <= wdata[8*b +: 8];
      end
    end
  end

endmodule

`default_nettype wire
